//--- compile.f
+incdir+include
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/id_ex.sv
design/rv_execute.sv
design/rv_int_pipe.sv
verification/tb_rv_int_pipe.sv

//--- design/id_ex.sv
`timescale 1ns/1ns

module id_ex (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              flush_i,

    input  rv_pkg::data_t     reg1_data_i,
    input  rv_pkg::data_t     reg2_data_i,
    input  rv_pkg::reg_addr_t reg1_addr_i,
    input  rv_pkg::reg_addr_t reg2_addr_i,
    input  rv_pkg::reg_addr_t rd_addr_i,
    input  rv_pkg::imm_t      imm_i,
    input  logic              use_imm_i,
    input  rv_pkg::alu_op_e   alu_op_i,
    input  logic              wb_en_i,

    // value being written back this cycle
    input  logic              is_wb_i,
    input  rv_pkg::reg_addr_t wb_addr_i,
    input  rv_pkg::data_t     wb_data_i,

    output rv_pkg::data_t     reg1_data_o,
    output rv_pkg::data_t     reg2_data_o,
    output rv_pkg::reg_addr_t reg1_addr_o,
    output rv_pkg::reg_addr_t reg2_addr_o,
    output rv_pkg::reg_addr_t rd_addr_o,
    output rv_pkg::imm_t      imm_o,
    output logic              use_imm_o,
    output rv_pkg::alu_op_e   alu_op_o,
    output logic              wb_en_o
);
    import rv_pkg::*;

    data_t reg1_byp;
    data_t reg2_byp;

    // regfile is written at the same edge, so pick up the value in flight
    assign reg1_byp = (is_wb_i && reg1_addr_i == wb_addr_i) ? wb_data_i : reg1_data_i;
    assign reg2_byp = (is_wb_i && reg2_addr_i == wb_addr_i) ? wb_data_i : reg2_data_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg1_data_o <= '0;
            reg2_data_o <= '0;
            reg1_addr_o <= '0;
            reg2_addr_o <= '0;
            rd_addr_o   <= '0;
            imm_o       <= '0;
            use_imm_o   <= 1'b0;
            alu_op_o    <= ALU_ADD;
            wb_en_o     <= 1'b0;
        end else if (flush_i) begin
            // bubble
            reg1_data_o <= '0;
            reg2_data_o <= '0;
            reg1_addr_o <= '0;
            reg2_addr_o <= '0;
            rd_addr_o   <= '0;
            imm_o       <= '0;
            use_imm_o   <= 1'b0;
            alu_op_o    <= ALU_ADD;
            wb_en_o     <= 1'b0;
        end else begin
            reg1_data_o <= reg1_byp;
            reg2_data_o <= reg2_byp;
            reg1_addr_o <= reg1_addr_i;
            reg2_addr_o <= reg2_addr_i;
            rd_addr_o   <= rd_addr_i;
            imm_o       <= imm_i;
            use_imm_o   <= use_imm_i;
            alu_op_o    <= alu_op_i;
            wb_en_o     <= wb_en_i;
        end
    end

endmodule

//--- design/rv_decoder.sv
`timescale 1ns/1ns
`include "rv_defs.svh"

module rv_decoder (
    input  logic [31:0]       inst_i,
    output rv_pkg::reg_addr_t rs1_addr_o,
    output rv_pkg::reg_addr_t rs2_addr_o,
    output rv_pkg::reg_addr_t rd_addr_o,
    output rv_pkg::imm_t      imm_o,
    output logic              use_imm_o,
    output rv_pkg::alu_op_e   alu_op_o,
    output logic              wb_en_o
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd_field;
    reg_addr_t  rs1_field;
    reg_addr_t  rs2_field;
    logic       alt;
    logic       valid;
    alu_op_e    funct_op;

    assign opcode    = inst_i[6:0];
    assign rd_field  = inst_i[11:7];
    assign funct3    = inst_i[14:12];
    assign rs1_field = inst_i[19:15];
    assign rs2_field = inst_i[24:20];
    assign funct7    = inst_i[31:25];
    assign alt       = (funct7 == `RV_F7_ALT);

    // funct3 mapping shared by register and immediate forms
    // SUB only exists in the register form
    always_comb begin
        case (funct3)
            3'b000:  funct_op = (alt && opcode == `RV_OP_REG) ? ALU_SUB : ALU_ADD;
            3'b001:  funct_op = ALU_SLL;
            3'b010:  funct_op = ALU_SLT;
            3'b011:  funct_op = ALU_SLTU;
            3'b100:  funct_op = ALU_XOR;
            3'b101:  funct_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  funct_op = ALU_OR;
            default: funct_op = ALU_AND;
        endcase
    end

    always_comb begin
        valid      = 1'b0;
        rs1_addr_o = '0;
        rs2_addr_o = '0;
        imm_o      = '0;
        use_imm_o  = 1'b0;
        alu_op_o   = ALU_ADD;
        case (opcode)
            `RV_OP_REG: begin
                valid      = 1'b1;
                rs1_addr_o = rs1_field;
                rs2_addr_o = rs2_field;
                alu_op_o   = funct_op;
            end
            `RV_OP_IMM: begin
                valid      = 1'b1;
                rs1_addr_o = rs1_field;
                imm_o      = {{20{inst_i[31]}}, inst_i[31:20]};
                use_imm_o  = 1'b1;
                alu_op_o   = funct_op;
            end
            `RV_OP_LUI: begin
                valid     = 1'b1;
                imm_o     = {inst_i[31:12], 12'b0};
                use_imm_o = 1'b1;
                alu_op_o  = ALU_PASS_B;
            end
            default: begin
                // anything else becomes a bubble
                valid = 1'b0;
            end
        endcase
    end

    // no write-back ever targets x0
    assign rd_addr_o = valid ? rd_field : '0;
    assign wb_en_o   = valid && (rd_field != '0);

endmodule

//--- design/rv_execute.sv
`timescale 1ns/1ns

module rv_execute (
    input  logic              clk,
    input  logic              rst_n_i,

    input  rv_pkg::data_t     reg1_data_i,
    input  rv_pkg::data_t     reg2_data_i,
    input  rv_pkg::reg_addr_t reg1_addr_i,
    input  rv_pkg::reg_addr_t reg2_addr_i,
    input  rv_pkg::reg_addr_t rd_addr_i,
    input  rv_pkg::imm_t      imm_i,
    input  logic              use_imm_i,
    input  rv_pkg::alu_op_e   alu_op_i,
    input  logic              wb_en_i,

    output logic              wb_we_o,
    output rv_pkg::reg_addr_t wb_addr_o,
    output rv_pkg::data_t     wb_data_o
);
    import rv_pkg::*;

    data_t    op_a;
    data_t    op_b_reg;
    data_t    op_b;
    data_t    result;
    logic [4:0] shamt;

    // forward from the previous instruction, newer than the id_ex bypass
    assign op_a     = (wb_we_o && reg1_addr_i == wb_addr_o) ? wb_data_o : reg1_data_i;
    assign op_b_reg = (wb_we_o && reg2_addr_i == wb_addr_o) ? wb_data_o : reg2_data_i;
    assign op_b     = use_imm_i ? imm_i : op_b_reg;
    assign shamt    = op_b[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_SLL:    result = op_a << shamt;
            ALU_SLT:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   result = {31'b0, op_a < op_b};
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SRL:    result = op_a >> shamt;
            ALU_SRA:    result = $signed(op_a) >>> shamt;
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    // write-back enable
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= wb_en_i;
        end
    end

    // write-back payload, qualified by wb_we_o
    always_ff @(posedge clk) begin
        wb_addr_o <= rd_addr_i;
        wb_data_o <= result;
    end

    // relies on the decoder dropping rd == x0
    a_wb_not_x0: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wb_we_o |-> (wb_addr_o != '0)
    ) else $error("write-back names x0");

endmodule

//--- design/rv_int_pipe.sv
`timescale 1ns/1ns

module rv_int_pipe (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [31:0]       inst_i,
    input  logic              flush_i,
    output logic              wb_we_o,
    output rv_pkg::reg_addr_t wb_addr_o,
    output rv_pkg::data_t     wb_data_o
);
    import rv_pkg::*;

    // decode stage
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    imm_t      imm;
    logic      use_imm;
    alu_op_e   alu_op;
    logic      wb_en;
    data_t     rs1_data;
    data_t     rs2_data;

    // execute stage
    data_t     ex_reg1_data;
    data_t     ex_reg2_data;
    reg_addr_t ex_reg1_addr;
    reg_addr_t ex_reg2_addr;
    reg_addr_t ex_rd_addr;
    imm_t      ex_imm;
    logic      ex_use_imm;
    alu_op_e   ex_alu_op;
    logic      ex_wb_en;

    // write-back
    logic      wb_we;
    reg_addr_t wb_addr;
    data_t     wb_data;

    rv_decoder rv_decoder_inst (
        .inst_i     (inst_i),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rd_addr_o  (rd_addr),
        .imm_o      (imm),
        .use_imm_o  (use_imm),
        .alu_op_o   (alu_op),
        .wb_en_o    (wb_en)
    );

    rv_regfile rv_regfile_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .we_i       (wb_we),
        .waddr_i    (wb_addr),
        .wdata_i    (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    id_ex id_ex_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .reg1_data_i (rs1_data),
        .reg2_data_i (rs2_data),
        .reg1_addr_i (rs1_addr),
        .reg2_addr_i (rs2_addr),
        .rd_addr_i   (rd_addr),
        .imm_i       (imm),
        .use_imm_i   (use_imm),
        .alu_op_i    (alu_op),
        .wb_en_i     (wb_en),
        .is_wb_i     (wb_we),
        .wb_addr_i   (wb_addr),
        .wb_data_i   (wb_data),
        .reg1_data_o (ex_reg1_data),
        .reg2_data_o (ex_reg2_data),
        .reg1_addr_o (ex_reg1_addr),
        .reg2_addr_o (ex_reg2_addr),
        .rd_addr_o   (ex_rd_addr),
        .imm_o       (ex_imm),
        .use_imm_o   (ex_use_imm),
        .alu_op_o    (ex_alu_op),
        .wb_en_o     (ex_wb_en)
    );

    rv_execute rv_execute_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .reg1_data_i (ex_reg1_data),
        .reg2_data_i (ex_reg2_data),
        .reg1_addr_i (ex_reg1_addr),
        .reg2_addr_i (ex_reg2_addr),
        .rd_addr_i   (ex_rd_addr),
        .imm_i       (ex_imm),
        .use_imm_i   (ex_use_imm),
        .alu_op_i    (ex_alu_op),
        .wb_en_i     (ex_wb_en),
        .wb_we_o     (wb_we),
        .wb_addr_o   (wb_addr),
        .wb_data_o   (wb_data)
    );

    assign wb_we_o   = wb_we;
    assign wb_addr_o = wb_addr;
    assign wb_data_o = wb_data;

endmodule

//--- design/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

    // register and ALU values
    typedef logic [`RV_XLEN-1:0] data_t;

    // register index
    typedef logic [`RV_AWIDTH-1:0] reg_addr_t;

    // immediate, already sign extended or shifted into the upper bits
    typedef logic [`RV_XLEN-1:0] imm_t;

    // ALU operations
    // PASS_B forwards operand b untouched, used for LUI
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

endpackage

//--- design/rv_regfile.sv
`timescale 1ns/1ns
`include "rv_defs.svh"

module rv_regfile (
    input  logic              clk,
    input  logic              rst_n_i,
    input  rv_pkg::reg_addr_t rs1_addr_i,
    input  rv_pkg::reg_addr_t rs2_addr_i,
    input  logic              we_i,
    input  rv_pkg::reg_addr_t waddr_i,
    input  rv_pkg::data_t     wdata_i,
    output rv_pkg::data_t     rs1_data_o,
    output rv_pkg::data_t     rs2_data_o
);
    import rv_pkg::*;

    // x0 is not stored
    data_t regs [1:`RV_NREGS-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational reads, same-cycle writes are covered by the id_ex bypass
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    // the decoder filters rd == x0, so it never reaches the write port
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        we_i |-> (waddr_i != '0)
    ) else $error("regfile write to x0");

endmodule

//--- include/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath and register file sizes
`define RV_XLEN   32
`define RV_AWIDTH 5
`define RV_NREGS  32

// major opcodes handled by this slice
`define RV_OP_REG 7'b0110011
`define RV_OP_IMM 7'b0010011
`define RV_OP_LUI 7'b0110111

// funct7 for SUB and SRA/SRAI
`define RV_F7_ALT 7'b0100000

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the rv_int_pipe testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_rv_int_pipe \
    -f compile.f \
    -o sim_tb

./obj_dir/sim_tb | tee "$LOG"

if grep -q "Checks failed" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi
echo "simulation finished without failures"

//--- verification/tb_rv_int_pipe.sv
`timescale 1ns/1ns
`include "rv_defs.svh"

module tb_rv_int_pipe;
    import rv_pkg::*;

    localparam int          N_INST         = 2000;
    localparam int          DRAIN_CYCLES   = 4;
    localparam int          TIMEOUT_CYCLES = N_INST + 50;
    localparam logic [31:0] NOP            = 32'h0000_0013;

    // one write-back slot as the model sees it
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        data_t     data;
    } wb_exp_t;

    logic        clk;
    logic        rst_n_i;
    logic [31:0] inst_i;
    logic        flush_i;
    logic        wb_we_o;
    reg_addr_t   wb_addr_o;
    data_t       wb_data_o;

    data_t       model_regs [0:`RV_NREGS-1];
    wb_exp_t     exp_q [$];
    wb_exp_t     slot;
    logic [31:0] rng_state;
    int          err_count;
    int          check_count;
    int          slot_count;
    int          flush_count;
    int          step;
    int          cycle_count;

    rv_int_pipe rv_int_pipe_inst (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .inst_i    (inst_i),
        .flush_i   (flush_i),
        .wb_we_o   (wb_we_o),
        .wb_addr_o (wb_addr_o),
        .wb_data_o (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // mostly ALU ops on x0..x7 so hazards come often
    function automatic logic [31:0] random_inst();
        logic [31:0] ra;
        logic [31:0] rb;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [6:0]  bad_op;
        logic [31:0] word;
        ra  = next_rand();
        rb  = next_rand();
        rd  = {2'b00, ra[6:4]};
        rs1 = {2'b00, ra[9:7]};
        rs2 = {2'b00, ra[12:10]};
        f3  = ra[15:13];
        f7  = ((f3 == 3'b000 || f3 == 3'b101) && ra[16]) ? `RV_F7_ALT : 7'b0;
        if (ra[3:0] < 4'd7) begin
            word = {f7, rs2, rs1, f3, rd, `RV_OP_REG};
        end else if (ra[3:0] < 4'd13) begin
            imm = rb[11:0];
            // shift immediates keep a legal upper field
            if (f3 == 3'b001) begin
                imm[11:5] = 7'b0;
            end else if (f3 == 3'b101) begin
                imm[11:5] = f7;
            end
            word = {imm, rs1, f3, rd, `RV_OP_IMM};
        end else if (ra[3:0] < 4'd15) begin
            word = {rb[31:12], rd, `RV_OP_LUI};
        end else begin
            // load, store, branch or jal
            case (ra[18:17])
                2'd0:    bad_op = 7'b0000011;
                2'd1:    bad_op = 7'b0100011;
                2'd2:    bad_op = 7'b1100011;
                default: bad_op = 7'b1101111;
            endcase
            word = {rb[31:12], rd, bad_op};
        end
        return word;
    endfunction

    // RV32I funct3 table where the alternate funct7 picks SUB (register form only) and SRA
    function automatic alu_op_e op_for(input logic [2:0] f3, input logic alt,
                                       input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic data_t alu_ref(input alu_op_e op, input data_t a, input data_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << b[4:0];
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return b;
        endcase
    endfunction

    // executes the word sampled at this edge in program order
    task automatic model_step(input logic [31:0] inst, input logic flush);
        wb_exp_t   e;
        reg_addr_t rd;
        data_t     a;
        data_t     b;
        alu_op_e   op;
        logic      alt;
        e   = '0;
        rd  = inst[11:7];
        a   = model_regs[inst[19:15]];
        b   = '0;
        op  = ALU_ADD;
        alt = (inst[31:25] == `RV_F7_ALT);
        if (!flush && rd != '0) begin
            case (inst[6:0])
                `RV_OP_REG: begin
                    b    = model_regs[inst[24:20]];
                    op   = op_for(inst[14:12], alt, 1'b1);
                    e.we = 1'b1;
                end
                `RV_OP_IMM: begin
                    b    = {{20{inst[31]}}, inst[31:20]};
                    op   = op_for(inst[14:12], alt, 1'b0);
                    e.we = 1'b1;
                end
                `RV_OP_LUI: begin
                    b    = {inst[31:12], 12'b0};
                    op   = ALU_PASS_B;
                    e.we = 1'b1;
                end
                default: e.we = 1'b0;
            endcase
        end
        if (e.we) begin
            e.addr         = rd;
            e.data         = alu_ref(op, a, b);
            model_regs[rd] = e.data;
        end
        if (flush) begin
            flush_count++;
        end
        exp_q.push_back(e);
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERR %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERR %s expected x%0d actual x%0d", name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    // compare mid-cycle once the write-back ports have settled
    always @(negedge clk) begin
        if (exp_q.size() >= 2) begin
            slot = exp_q.pop_front();
            check_flag($sformatf("wb_we slot %0d", slot_count), slot.we, wb_we_o);
            if (slot.we) begin
                check_addr($sformatf("wb_addr slot %0d", slot_count), slot.addr, wb_addr_o);
                check_data($sformatf("wb_data slot %0d", slot_count), slot.data, wb_data_o);
            end
            slot_count++;
        end
    end

    initial begin
        rng_state   = 32'h5a43_f7c4;
        err_count   = 0;
        check_count = 0;
        slot_count  = 0;
        flush_count = 0;
        step        = 0;
        cycle_count = 0;
        for (int i = 0; i < `RV_NREGS; i++) begin
            model_regs[i] = '0;
        end
        rst_n_i = 1'b0;
        inst_i  = NOP;
        flush_i = 1'b0;
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        // the releasing edge still sees reset and nothing enters id_ex
        exp_q.push_back('0);
        while (step < N_INST + DRAIN_CYCLES && cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
            model_step(inst_i, flush_i);
            step++;
            if (step <= N_INST) begin
                inst_i  <= random_inst();
                flush_i <= ((next_rand() & 32'hf) == 32'h0);
            end else begin
                inst_i  <= NOP;
                flush_i <= 1'b0;
            end
        end
        repeat (2) @(posedge clk);
        if (step < N_INST + DRAIN_CYCLES) begin
            $display("run stopped at the cycle limit after %0d cycles", cycle_count);
        end
        $display("cycles %0d, flushes %0d, checks %0d, errors %0d",
                 cycle_count, flush_count, check_count, err_count);
        if (err_count != 0 || step < N_INST + DRAIN_CYCLES) begin
            $display("Checks failed");
        end else begin
            $display("All checks passed");
        end
        $finish;
    end

endmodule
